//--- logic/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // ####################
    // Widths

    localparam int xlen = 32;
    localparam int div_count_width = 6; // Must hold the value xlen

    typedef logic [xlen-1:0] word_t;

    // ####################
    // Operations and payloads

    typedef enum logic [2:0] {
        op_mult  = 3'd0,
        op_multu = 3'd1,
        op_div   = 3'd2,
        op_divu  = 3'd3,
        op_mthi  = 3'd4,
        op_mtlo  = 3'd5
    } muldiv_op_e;

    typedef struct packed {
        muldiv_op_e op;
        word_t      a;
        word_t      b;
    } muldiv_req_t;

    typedef struct packed {
        word_t a;
        word_t b;
        logic  is_signed;
    } unit_req_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

`default_nettype wire

//--- logic/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  muldiv_pkg::unit_req_t operands,
    output logic                  ack,
    output muldiv_pkg::hilo_t     result
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        free,
        by_zero,
        running,
        done
    } state_e;

    state_e                     state;
    logic [2*xlen:0]            shreg;   // Remainder in the top half, quotient shifts in at bit 0
    word_t                      divisor;
    logic [div_count_width-1:0] count;
    logic                       quot_neg;
    logic                       rem_neg;

    logic [xlen:0] trial;
    word_t         a_mag;
    word_t         b_mag;
    word_t         quot;
    word_t         rem;

    assign a_mag = (operands.is_signed && operands.a[xlen-1]) ? -operands.a : operands.a;
    assign b_mag = (operands.is_signed && operands.b[xlen-1]) ? -operands.b : operands.b;

    // Borrow out in the top bit means the divisor does not fit
    assign trial = {1'b0, shreg[2*xlen-1:xlen]} - {1'b0, divisor};

    assign quot = shreg[xlen-1:0];
    assign rem  = shreg[2*xlen:xlen+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= free;
            ack   <= 1'b0;
        end else begin
            case (state)
                free: begin
                    if (req) begin
                        if (operands.b == '0) begin
                            state <= by_zero;
                        end else begin
                            shreg    <= {{xlen{1'b0}}, a_mag, 1'b0};
                            divisor  <= b_mag;
                            count    <= '0;
                            quot_neg <= operands.is_signed
                                        && (operands.a[xlen-1] ^ operands.b[xlen-1]);
                            // Remainder follows the dividend
                            rem_neg  <= operands.is_signed && operands.a[xlen-1];
                            state    <= running;
                        end
                    end
                end

                by_zero: begin
                    result <= '0;
                    ack    <= 1'b1;
                    state  <= done;
                end

                running: begin
                    if (count != div_count_width'(xlen)) begin
                        if (trial[xlen]) begin
                            shreg <= {shreg[2*xlen-1:0], 1'b0};
                        end else begin
                            shreg <= {trial[xlen-1:0], shreg[xlen-1:0], 1'b1};
                        end
                        count <= count + 1'b1;
                    end else begin
                        // Negating 0x80000000 wraps to itself, which covers min / -1
                        result.lo <= quot_neg ? -quot : quot;
                        result.hi <= rem_neg ? -rem : rem;
                        ack       <= 1'b1;
                        state     <= done;
                    end
                end

                done: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= free;
                    end
                end

                default: begin
                    state <= free;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module multiplier (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  muldiv_pkg::unit_req_t operands,
    output logic                  ack,
    output muldiv_pkg::hilo_t     result
);
    import muldiv_pkg::*;

    logic signed [xlen:0]     a_ext;
    logic signed [xlen:0]     b_ext;
    logic signed [2*xlen-1:0] product;
    logic                     stage_valid;
    logic                     start;

    // A request is new only while nothing is in flight and ack is low
    assign start = req && !stage_valid && !ack;

    assign product = a_ext * b_ext;

    // ####################
    // Datapath

    always_ff @(posedge clk) begin
        if (start) begin
            a_ext <= {operands.is_signed & operands.a[xlen-1], operands.a};
            b_ext <= {operands.is_signed & operands.b[xlen-1], operands.b};
        end
        if (stage_valid) begin
            result <= hilo_t'(product);
        end
    end

    // ####################
    // Request tracker

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            ack         <= 1'b0;
        end else begin
            stage_valid <= start;
            if (stage_valid) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/hilo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_req,
    input  muldiv_pkg::muldiv_req_t op,
    output logic                    op_ack,
    output logic                    div_req,
    output logic                    mul_req,
    output muldiv_pkg::unit_req_t   unit_op,
    input  logic                    div_ack,
    input  logic                    mul_ack,
    input  muldiv_pkg::hilo_t       div_result,
    input  muldiv_pkg::hilo_t       mul_result,
    output muldiv_pkg::hilo_t       hilo
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_busy,
        ctrl_hold
    } state_e;

    state_e state;
    logic   use_div;
    logic   op_signed;
    logic   target_div;  // Unit picked when the operation was accepted
    logic   unit_ack;
    hilo_t  unit_result;

    assign use_div   = (op.op == op_div) || (op.op == op_divu);
    assign op_signed = (op.op == op_div) || (op.op == op_mult);

    assign unit_ack    = target_div ? div_ack : mul_ack;
    assign unit_result = target_div ? div_result : mul_result;

    // Operands stay put from acceptance until the next operation
    always_ff @(posedge clk) begin
        if (state == ctrl_idle && op_req) begin
            target_div        <= use_div;
            unit_op.a         <= op.a;
            unit_op.b         <= op.b;
            unit_op.is_signed <= op_signed;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ctrl_idle;
            op_ack  <= 1'b0;
            div_req <= 1'b0;
            mul_req <= 1'b0;
            hilo    <= '0;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (op_req) begin
                        case (op.op)
                            op_mthi: begin
                                hilo.hi <= op.a;
                                op_ack  <= 1'b1;
                                state   <= ctrl_hold;
                            end
                            op_mtlo: begin
                                hilo.lo <= op.a;
                                op_ack  <= 1'b1;
                                state   <= ctrl_hold;
                            end
                            default: begin
                                div_req <= use_div;
                                mul_req <= !use_div;
                                state   <= ctrl_busy;
                            end
                        endcase
                    end
                end

                ctrl_busy: begin
                    if (unit_ack) begin
                        hilo    <= unit_result;
                        div_req <= 1'b0;  // Result is captured, so the unit can release
                        mul_req <= 1'b0;
                        op_ack  <= 1'b1;
                        state   <= ctrl_hold;
                    end
                end

                ctrl_hold: begin
                    // Wait for both sides of the four-phase exchange to return to zero
                    if (!op_req && !div_ack && !mul_ack) begin
                        op_ack <= 1'b0;
                        state  <= ctrl_idle;
                    end
                end

                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    op_req,
    input  muldiv_pkg::muldiv_req_t op,
    output logic                    op_ack,
    output muldiv_pkg::hilo_t       hilo
);
    import muldiv_pkg::*;

    logic      div_req;
    logic      div_ack;
    logic      mul_req;
    logic      mul_ack;
    unit_req_t unit_op;     // Both units share it because only one is requested at a time
    hilo_t     div_result;
    hilo_t     mul_result;

    hilo_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .op_req     (op_req),
        .op         (op),
        .op_ack     (op_ack),
        .div_req    (div_req),
        .mul_req    (mul_req),
        .unit_op    (unit_op),
        .div_ack    (div_ack),
        .mul_ack    (mul_ack),
        .div_result (div_result),
        .mul_result (mul_result),
        .hilo       (hilo)
    );

    divider i_div (
        .clk      (clk),
        .rst      (rst),
        .req      (div_req),
        .operands (unit_op),
        .ack      (div_ack),
        .result   (div_result)
    );

    multiplier i_mul (
        .clk      (clk),
        .rst      (rst),
        .req      (mul_req),
        .operands (unit_op),
        .ack      (mul_ack),
        .result   (mul_result)
    );

endmodule

`default_nettype wire

//--- verification/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
    import muldiv_pkg::*;

    typedef struct packed {
        muldiv_req_t req;
        hilo_t       expected;
    } vector_t;

    localparam int num_directed   = 24;
    localparam int num_random     = 16;
    localparam int timeout_cycles = 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        op_req;
    muldiv_req_t op;
    logic        op_ack;
    hilo_t       hilo;

    vector_t vectors[$];
    int      check_count   = 0;
    int      error_count   = 0;
    int      timeout_count = 0;

    // ####################
    // Directed table with the expected hilo written as {hi, lo}

    vector_t directed [num_directed] = '{
        '{'{op_mthi,  32'h12345678, 32'h0},        {32'h12345678, 32'h00000000}},
        '{'{op_mtlo,  32'h9abcdef0, 32'h0},        {32'h12345678, 32'h9abcdef0}},
        '{'{op_divu,  32'd100,      32'd7},        {32'h00000002, 32'h0000000e}},
        '{'{op_divu,  32'd7,        32'd100},      {32'h00000007, 32'h00000000}},
        '{'{op_divu,  32'hffffffff, 32'h00000010}, {32'h0000000f, 32'h0fffffff}},
        '{'{op_divu,  32'h80000000, 32'd3},        {32'h00000002, 32'h2aaaaaaa}},
        '{'{op_divu,  32'h12345678, 32'h12345678}, {32'h00000000, 32'h00000001}},
        '{'{op_divu,  32'hdeadbeef, 32'h00010000}, {32'h0000beef, 32'h0000dead}},
        '{'{op_div,   32'd100,      32'd7},        {32'h00000002, 32'h0000000e}},
        '{'{op_div,   32'hffffff9c, 32'd7},        {32'hfffffffe, 32'hfffffff2}},
        '{'{op_div,   32'd100,      32'hfffffff9}, {32'h00000002, 32'hfffffff2}},
        '{'{op_div,   32'hffffff9c, 32'hfffffff9}, {32'hfffffffe, 32'h0000000e}},
        '{'{op_div,   32'h80000000, 32'hffffffff}, {32'h00000000, 32'h80000000}},
        '{'{op_div,   32'hfffffffb, 32'h00000000}, {32'h00000000, 32'h00000000}},
        '{'{op_mthi,  32'hcafef00d, 32'h0},        {32'hcafef00d, 32'h00000000}},
        '{'{op_divu,  32'hffffffff, 32'h00000000}, {32'h00000000, 32'h00000000}},
        '{'{op_mult,  32'hffffffff, 32'hffffffff}, {32'h00000000, 32'h00000001}},
        '{'{op_multu, 32'hffffffff, 32'hffffffff}, {32'hfffffffe, 32'h00000001}},
        '{'{op_mult,  32'h7fffffff, 32'h7fffffff}, {32'h3fffffff, 32'h00000001}},
        '{'{op_mult,  32'h80000000, 32'h80000000}, {32'h40000000, 32'h00000000}},
        '{'{op_mult,  32'hfffffffd, 32'd5},        {32'hffffffff, 32'hfffffff1}},
        '{'{op_multu, 32'hfffffffd, 32'd5},        {32'h00000004, 32'hfffffff1}},
        '{'{op_mtlo,  32'h0badc0de, 32'h0},        {32'h00000004, 32'h0badc0de}},
        '{'{op_mult,  32'h80000000, 32'h7fffffff}, {32'hc0000000, 32'h80000000}}
    };

    muldiv_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .op_req (op_req),
        .op     (op),
        .op_ack (op_ack),
        .hilo   (hilo)
    );

    always #2 clk = ~clk;

    // ####################
    // Reference model and helpers

    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic hilo_t expected_result(muldiv_req_t req, hilo_t prev);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        hilo_t           res;
        sa  = $signed(req.a);
        sb  = $signed(req.b);
        ua  = {32'b0, req.a};
        ub  = {32'b0, req.b};
        res = prev;
        case (req.op)
            op_mult:  res = hilo_t'(sa * sb);
            op_multu: res = hilo_t'(ua * ub);
            op_div: begin
                if (sb == 0) begin
                    res = '0;
                end else begin
                    res.lo = word_t'(sa / sb);  // Min / -1 is 2**31 here and wraps on truncation
                    res.hi = word_t'(sa % sb);
                end
            end
            op_divu: begin
                if (ub == 0) begin
                    res = '0;
                end else begin
                    res.lo = word_t'(ua / ub);
                    res.hi = word_t'(ua % ub);
                end
            end
            op_mthi:  res.hi = req.a;
            op_mtlo:  res.lo = req.a;
            default:  res = prev;
        endcase
        return res;
    endfunction

    task automatic check_hilo(input string name, input hilo_t got, input hilo_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_for_ack(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        while (op_ack !== level && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (op_ack === level);
        if (!ok) begin
            timeout_count++;
            $display("Timeout at %0t: op_ack did not reach %b within %0d cycles",
                     $time, level, timeout_cycles);
        end
    endtask

    task automatic build_vectors();
        vector_t v;
        hilo_t   model_hilo;
        word_t   rng;
        model_hilo = '0;
        foreach (directed[i]) begin
            vectors.push_back(directed[i]);
            model_hilo = directed[i].expected;
        end
        rng = 32'd12;
        for (int i = 0; i < num_random; i++) begin
            rng          = xorshift(rng);
            v.req.op     = muldiv_op_e'(3'(rng % 6));
            rng          = xorshift(rng);
            v.req.a      = rng;
            rng          = xorshift(rng);
            v.req.b      = rng >> rng[3:0];  // Smaller divisors give wider quotients
            v.expected   = expected_result(v.req, model_hilo);
            model_hilo   = v.expected;
            vectors.push_back(v);
        end
    endtask

    // ####################
    // Main sequence

    initial begin
        logic ok;
        rst    = 1'b1;
        op_req = 1'b0;
        op     = '0;
        build_vectors();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("op_ack", op_ack, 1'b0);
        check_hilo("hilo", hilo, '0);

        foreach (vectors[i]) begin
            op     = vectors[i].req;
            op_req = 1'b1;
            wait_for_ack(1'b1, ok);
            if (!ok) begin
                break;
            end
            check_hilo($sformatf("hilo (vector %0d)", i), hilo, vectors[i].expected);
            @(posedge clk);
            #1;
            check_bit("op_ack", op_ack, 1'b1);  // Held request keeps the ack high
            op_req = 1'b0;
            wait_for_ack(1'b0, ok);
            if (!ok) begin
                break;
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/muldiv_pkg.sv
logic/divider.sv
logic/multiplier.sv
logic/hilo_ctrl.sv
logic/muldiv_top.sv
verification/muldiv_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := muldiv_tb
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
